// File: Bender.yml
package:
  name: read_buffer

sources:
  # Packages first, then the RTL in dependency order
  - files:
      - hdl/capi_pkg.sv
      - hdl/buffer_pkg.sv
      - hdl/tag_command_table.sv
      - hdl/read_data_control.sv
      - hdl/half_line_store.sv
      - hdl/line_release.sv
      - hdl/read_buffer_top.sv
  - target: test
    files:
      - bench/read_buffer_assertions.sv
      - bench/read_buffer_tb.sv

// File: bench/read_buffer_assertions.sv
`timescale 1ns/1ps

module read_buffer_assertions
  import buffer_pkg::*;
(
  input logic                        clock,
  input logic                        rstn,
  input logic                        enabled_in,
  input logic                        line_valid,
  input logic [HALF_INDEX_WIDTH-1:0] line_half,
  input logic                        read_data,
  input logic                        wed_data,
  input logic [1:0]                  data_read_error
);

  //////////////////////////////////////////////////////////////////////
  // Beat order and flags
  //////////////////////////////////////////////////////////////////////

  // Half 1 always on the cycle right after half 0
  assert property (@(posedge clock) disable iff (!rstn)
    line_valid && line_half == '0 |=> line_valid && line_half == HALF_INDEX_WIDTH'(1))
    else $error("half 1 beat did not follow a half 0 beat");

  assert property (@(posedge clock) disable iff (!rstn) !(read_data && wed_data))
    else $error("read_data and wed_data high together");

  //////////////////////////////////////////////////////////////////////
  // Enable and reset
  //////////////////////////////////////////////////////////////////////

  // Enable is registered before it gates the beat outputs
  assert property (@(posedge clock) disable iff (!rstn)
    !$past(enabled_in, 2) |-> !line_valid && !read_data && !wed_data)
    else $error("line beat while enable was low");

  // Error pulse trails the write by the latch stage and three pipeline stages
  assert property (@(posedge clock) disable iff (!rstn)
    !$past(enabled_in, 5) |-> data_read_error == 2'b00)
    else $error("parity error reported for a write taken while disabled");

  assert property (@(posedge clock) !rstn |=> data_read_error == 2'b00 && !line_valid)
    else $error("outputs active right after reset");

endmodule

bind read_buffer_top read_buffer_assertions i_read_buffer_assertions (
  .clock          (clock),
  .rstn           (rstn),
  .enabled_in     (enabled_in),
  .line_valid     (line_valid),
  .line_half      (line_half),
  .read_data      (read_data),
  .wed_data       (wed_data),
  .data_read_error(data_read_error)
);

// File: bench/read_buffer_tb.sv
`timescale 1ns/1ps

module read_buffer_tb
  import capi_pkg::*;
  import buffer_pkg::*;
();

  localparam int CLOCK_PERIOD    = 40;
  localparam int SEED            = 32'h2b508dc7;
  localparam int LINE_COUNT      = 16;
  localparam int REISSUE_COUNT   = 4;
  localparam int OFFLINE_COUNT   = 4;
  localparam int TRANSACTIONS    = 4 * (LINE_COUNT + REISSUE_COUNT + OFFLINE_COUNT);
  localparam int WATCHDOG_CYCLES = TRANSACTIONS * 20 + 100;

  // Expected output beat
  typedef struct {
    int                    cycle;
    logic [TAG_WIDTH-1:0]  tag;
    int                    half;
    logic [HALF_WIDTH+1:0] word;
  } beat_t;

  logic                        clock = 1'b0;
  logic                        rstn;
  logic                        enabled_in;
  logic                        cmd_valid;
  logic [TAG_WIDTH-1:0]        cmd_tag;
  cmd_type_e                   cmd_type;
  logic                        write_valid;
  logic [TAG_WIDTH-1:0]        write_tag;
  logic                        write_tag_parity;
  logic [HALF_INDEX_WIDTH-1:0] write_half;
  logic [HALF_WIDTH-1:0]       write_data;
  logic [DW_PER_HALF-1:0]      write_parity;
  logic                        response_valid;
  logic [TAG_WIDTH-1:0]        response_tag;
  logic                        line_valid;
  logic [TAG_WIDTH-1:0]        line_tag;
  logic [HALF_INDEX_WIDTH-1:0] line_half;
  logic [HALF_WIDTH-1:0]       line_data;
  logic                        read_data;
  logic                        wed_data;
  logic [1:0]                  data_read_error;

  // Model of stored words {read flag, wed flag, data} per half and tag
  cmd_type_e             model_type [TAG_COUNT];
  logic [HALF_WIDTH+1:0] model_line [HALF_COUNT][TAG_COUNT];
  logic [1:0]            error_due [int];
  beat_t                 beats [$];
  int                    last_release = -100;
  bit                    prev_enable;
  int                    cycle = 0;
  int                    checks;
  int                    mismatches;
  int                    other_errors;

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  always @(posedge clock) cycle <= cycle + 1;

  read_buffer_top i_read_buffer_top (.*);

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  function automatic logic [HALF_WIDTH-1:0] random_half();
    logic [HALF_WIDTH-1:0] value;
    for (int i = 0; i < HALF_WIDTH / 32; i++) begin
      value[i*32 +: 32] = $urandom;
    end
    return value;
  endfunction

  task automatic idle(input int count);
    repeat (count) begin
      @(posedge clock);
      cmd_valid      <= 1'b0;
      write_valid    <= 1'b0;
      response_valid <= 1'b0;
    end
  endtask

  task automatic set_enable(input logic level);
    @(posedge clock);
    enabled_in     <= level;
    cmd_valid      <= 1'b0;
    write_valid    <= 1'b0;
    response_valid <= 1'b0;
  endtask

  task automatic issue_command(input logic [TAG_WIDTH-1:0] tag, input cmd_type_e kind);
    @(posedge clock);
    cmd_valid      <= 1'b1;
    cmd_tag        <= tag;
    cmd_type       <= kind;
    write_valid    <= 1'b0;
    response_valid <= 1'b0;
  endtask

  task automatic deliver_half(
    input logic [TAG_WIDTH-1:0]  tag,
    input int                    half,
    input logic [HALF_WIDTH-1:0] data,
    input bit                    bad_tag,
    input bit                    bad_dw
  );
    logic [DW_PER_HALF-1:0] parity;
    // Odd parity per double word
    for (int i = 0; i < DW_PER_HALF; i++) begin
      parity[i] = ~(^data[i*DW_WIDTH +: DW_WIDTH]);
    end
    if (bad_dw) begin
      parity[$urandom_range(DW_PER_HALF - 1)] ^= 1'b1;
    end
    @(posedge clock);
    cmd_valid        <= 1'b0;
    write_valid      <= 1'b1;
    write_tag        <= tag;
    write_tag_parity <= ~(^tag) ^ bad_tag;
    write_half       <= half[HALF_INDEX_WIDTH-1:0];
    write_data       <= data;
    write_parity     <= parity;
    response_valid   <= 1'b0;
  endtask

  task automatic send_response(input logic [TAG_WIDTH-1:0] tag);
    @(posedge clock);
    cmd_valid      <= 1'b0;
    write_valid    <= 1'b0;
    response_valid <= 1'b1;
    response_tag   <= tag;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model and checks sampled on the falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic track_inputs();
    logic  tag_bad;
    logic  data_bad;
    int    release_at;
    beat_t beat;
    if (cmd_valid) begin
      model_type[cmd_tag] = cmd_type;
    end
    // Inputs seen now are sampled on the next rising edge
    if (write_valid && prev_enable) begin
      tag_bad  = (^{write_tag, write_tag_parity}) != 1'b1;
      data_bad = 1'b0;
      for (int i = 0; i < DW_PER_HALF; i++) begin
        if ((^{write_data[i*DW_WIDTH +: DW_WIDTH], write_parity[i]}) != 1'b1) begin
          data_bad = 1'b1;
        end
      end
      error_due[cycle + 1 + ERROR_LATENCY] = {tag_bad, data_bad};
      if (model_type[write_tag] == CMD_READ || model_type[write_tag] == CMD_WED) begin
        model_line[write_half][write_tag] = {model_type[write_tag] == CMD_READ,
                                             model_type[write_tag] == CMD_WED, write_data};
      end
    end
    // One line every two cycles on the output
    if (response_valid && prev_enable) begin
      release_at = cycle + 1 + RELEASE_LATENCY;
      if (release_at < last_release + 2) begin
        release_at = last_release + 2;
      end
      for (int h = 0; h < HALF_COUNT; h++) begin
        beat.cycle = release_at + h;
        beat.tag   = response_tag;
        beat.half  = h;
        beat.word  = model_line[h][response_tag];
        beats.push_back(beat);
      end
      last_release = release_at;
    end
  endtask

  task automatic check_outputs();
    logic [1:0] expected_error;
    beat_t      beat;
    expected_error = 2'b00;
    if (error_due.exists(cycle)) begin
      expected_error = error_due[cycle];
      error_due.delete(cycle);
    end
    checks++;
    if (data_read_error !== expected_error) begin
      mismatches++;
      $display("mismatch at %0t: data_read_error %b, expected %b", $time, data_read_error,
               expected_error);
    end
    if (line_valid === 1'b1) begin
      if (beats.size() == 0) begin
        other_errors++;
        $display("Unexpected line beat for tag %0h at %0t", line_tag, $time);
      end else begin
        beat = beats.pop_front();
        checks++;
        if (beat.cycle != cycle || line_tag !== beat.tag ||
            line_half !== HALF_INDEX_WIDTH'(beat.half)) begin
          mismatches++;
          $display("mismatch at %0t: beat tag %0h half %0d, expected tag %0h half %0d at cycle %0d",
                   $time, line_tag, line_half, beat.tag, beat.half, beat.cycle);
        end
        if (line_data !== beat.word[HALF_WIDTH-1:0] || read_data !== beat.word[HALF_WIDTH+1] ||
            wed_data !== beat.word[HALF_WIDTH]) begin
          mismatches++;
          $display("mismatch at %0t: data or flags of tag %0h half %0d, read %b wed %b",
                   $time, beat.tag, beat.half, read_data, wed_data);
        end
      end
    end else begin
      if (line_valid !== 1'b0 || read_data !== 1'b0 || wed_data !== 1'b0) begin
        mismatches++;
        $display("mismatch at %0t: output strobes active without a line beat", $time);
      end
      if (beats.size() != 0 && beats[0].cycle <= cycle) begin
        other_errors++;
        $display("Line beat for tag %0h half %0d did not appear at cycle %0d", beats[0].tag,
                 beats[0].half, beats[0].cycle);
        beats.delete(0);
      end
    end
  endtask

  always @(negedge clock) begin
    if (rstn) begin
      track_inputs();
      check_outputs();
    end
    prev_enable = enabled_in;
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [TAG_WIDTH-1:0] tags [LINE_COUNT];
    bit                   used [TAG_COUNT];
    int                   order [2*LINE_COUNT];
    int                   pick;
    int                   swap;
    int                   burst;
    int                   next;

    void'($urandom(SEED));
    rstn             = 1'b1;
    enabled_in       = 1'b1;
    cmd_valid        = 1'b0;
    cmd_tag          = '0;
    cmd_type         = CMD_INVALID;
    write_valid      = 1'b0;
    write_tag        = '0;
    write_tag_parity = 1'b0;
    write_half       = '0;
    write_data       = '0;
    write_parity     = '0;
    response_valid   = 1'b0;
    response_tag     = '0;
    for (int i = 0; i < TAG_COUNT; i++) begin
      model_type[i] = CMD_INVALID;
    end
    #1 rstn = 1'b0;
    repeat (3) @(posedge clock);
    rstn <= 1'b1;
    idle(3);

    // Distinct tags issued as read or wed commands
    for (int i = 0; i < LINE_COUNT; i++) begin
      do begin
        pick = $urandom_range(TAG_COUNT - 1);
      end while (used[pick]);
      used[pick] = 1'b1;
      tags[i]    = TAG_WIDTH'(pick);
      issue_command(tags[i], ($urandom_range(1) == 0) ? CMD_READ : CMD_WED);
    end

    // All halves in shuffled order with some bad parity
    for (int i = 0; i < 2 * LINE_COUNT; i++) begin
      order[i] = i;
    end
    for (int i = 2 * LINE_COUNT - 1; i > 0; i--) begin
      pick        = $urandom_range(i);
      swap        = order[i];
      order[i]    = order[pick];
      order[pick] = swap;
    end
    for (int k = 0; k < 2 * LINE_COUNT; k++) begin
      deliver_half(tags[order[k] / 2], order[k] % 2, random_half(),
                   (k == 0) || ($urandom_range(5) == 0), (k == 1) || ($urandom_range(5) == 0));
    end
    idle(4);

    // Short bursts of back to back responses
    next = 0;
    while (next < LINE_COUNT) begin
      burst = $urandom_range(3, 1);
      for (int b = 0; b < burst && next < LINE_COUNT; b++) begin
        send_response(tags[next]);
        next++;
      end
      idle(2 * burst + $urandom_range(2));
    end
    idle(6);

    // Write commands keep the old line
    for (int i = 0; i < REISSUE_COUNT; i++) begin
      issue_command(tags[i], CMD_WRITE);
    end
    for (int i = 0; i < REISSUE_COUNT; i++) begin
      deliver_half(tags[i], 0, random_half(), 1'b0, 1'b0);
      deliver_half(tags[i], 1, random_half(), 1'b0, 1'b0);
    end
    idle(4);
    for (int i = 0; i < REISSUE_COUNT; i++) begin
      send_response(tags[i]);
      idle(2);
    end
    idle(6);

    // Nothing is taken while disabled
    set_enable(1'b0);
    idle(3);
    for (int i = REISSUE_COUNT; i < REISSUE_COUNT + OFFLINE_COUNT; i++) begin
      deliver_half(tags[i], 0, random_half(), 1'b1, 1'b1);
      deliver_half(tags[i], 1, random_half(), 1'b0, 1'b0);
      send_response(tags[i]);
    end
    idle(3);
    set_enable(1'b1);
    idle(3);
    for (int i = REISSUE_COUNT; i < REISSUE_COUNT + OFFLINE_COUNT; i++) begin
      send_response(tags[i]);
      idle(2);
    end
    idle(12);

    if (beats.size() != 0) begin
      other_errors++;
      $display("%0d expected line beats never appeared", beats.size());
    end
    $display("Checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errors);
    if (mismatches + other_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLOCK_PERIOD);
    $display("Timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errors);
    $display("Errors found");
    $finish;
  end

endmodule

// File: hdl/buffer_pkg.sv
package buffer_pkg;

  //////////////////////////////////////////////////////////////////////
  // Line geometry
  //////////////////////////////////////////////////////////////////////

  localparam int TAG_COUNT        = 256;
  localparam int HALF_COUNT       = 2;
  localparam int HALF_INDEX_WIDTH = $clog2(HALF_COUNT);
  localparam int DW_PER_HALF      = 8;
  localparam int HALF_WIDTH       = 512;
  localparam int DW_WIDTH         = HALF_WIDTH / DW_PER_HALF;

  // Stored word is {read flag, wed flag, half data}
  localparam int STORE_WIDTH    = HALF_WIDTH + 2;
  localparam int STORE_READ_BIT = STORE_WIDTH - 1;
  localparam int STORE_WED_BIT  = STORE_WIDTH - 2;

  // Pending responses waiting for their two output beats
  localparam int RESPONSE_QUEUE_DEPTH = 8;
  localparam int QUEUE_PTR_WIDTH      = $clog2(RESPONSE_QUEUE_DEPTH);

  //////////////////////////////////////////////////////////////////////
  // Latencies in clock cycles
  //////////////////////////////////////////////////////////////////////

  // Response edge to the half 0 beat
  localparam int RELEASE_LATENCY = 2;
  // Half write edge to its error pulse
  localparam int ERROR_LATENCY   = 3;

endpackage

// File: hdl/capi_pkg.sv
package capi_pkg;

  //////////////////////////////////////////////////////////////////////
  // Command kinds seen on the accelerator port
  //////////////////////////////////////////////////////////////////////

  // Kept per tag when the command goes out
  typedef enum logic [1:0] {
    CMD_INVALID = 2'b00,
    CMD_READ    = 2'b01,
    CMD_WED     = 2'b10,
    CMD_WRITE   = 2'b11
  } cmd_type_e;

  //////////////////////////////////////////////////////////////////////
  // Tag and parity conventions
  //////////////////////////////////////////////////////////////////////

  // One tag per outstanding command
  localparam int TAG_WIDTH = 8;

  // Data bits plus parity bit always hold an odd count of ones
  localparam logic ODD_PARITY = 1'b1;

endpackage

// File: hdl/half_line_store.sv
`timescale 1ns/1ps

module half_line_store #(
  parameter int WIDTH = 64,
  parameter int DEPTH = 256
) (
  input  logic                     clock,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  logic [WIDTH-1:0]         data_in,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output logic [WIDTH-1:0]         data_out
);

  logic [WIDTH-1:0] mem [DEPTH];

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (we) begin
      mem[wr_addr] <= data_in;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registered read port
  //////////////////////////////////////////////////////////////////////

  // Old contents come back on a same address collision
  always_ff @(posedge clock) begin
    data_out <= mem[rd_addr];
  end

endmodule

// File: hdl/line_release.sv
`timescale 1ns/1ps

module line_release
  import capi_pkg::*;
  import buffer_pkg::*;
(
  input  logic                                  clock,
  input  logic                                  rstn,
  input  logic                                  enabled_in,
  input  logic                                  response_valid,
  input  logic [TAG_WIDTH-1:0]                  response_tag,
  output logic [TAG_WIDTH-1:0]                  rd_tag,
  input  logic [HALF_COUNT-1:0][STORE_WIDTH-1:0] half_words,
  output logic                                  line_valid,
  output logic [TAG_WIDTH-1:0]                  line_tag,
  output logic [HALF_INDEX_WIDTH-1:0]           line_half,
  output logic [HALF_WIDTH-1:0]                 line_data,
  output logic                                  read_data,
  output logic                                  wed_data
);

  logic                       enabled;

  logic [TAG_WIDTH-1:0]       queue [RESPONSE_QUEUE_DEPTH];
  logic [QUEUE_PTR_WIDTH:0]   wr_ptr;
  logic [QUEUE_PTR_WIDTH:0]   rd_ptr;
  logic                       queue_empty;

  logic                       issue;
  logic                       issue_q;
  logic [TAG_WIDTH-1:0]       issue_tag_q;
  logic                       hold_valid;
  logic [STORE_WIDTH-1:0]     hold_word;

  //////////////////////////////////////////////////////////////////////
  // Response queue
  //////////////////////////////////////////////////////////////////////

  assign queue_empty = (wr_ptr == rd_ptr);

  // One line every other cycle since each takes two beats
  assign issue  = enabled & ~queue_empty & ~issue_q;
  assign rd_tag = queue[rd_ptr[QUEUE_PTR_WIDTH-1:0]];

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled <= 1'b0;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
    end else begin
      enabled <= enabled_in;
      if (!enabled) begin
        // Drop anything pending
        wr_ptr <= '0;
        rd_ptr <= '0;
      end else begin
        if (response_valid) begin
          wr_ptr <= wr_ptr + 1'b1;
        end
        if (issue) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (enabled && response_valid) begin
      queue[wr_ptr[QUEUE_PTR_WIDTH-1:0]] <= response_tag;
    end
    if (issue) begin
      issue_tag_q <= rd_tag;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output beats
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      issue_q    <= 1'b0;
      hold_valid <= 1'b0;
      line_valid <= 1'b0;
      line_half  <= '0;
      read_data  <= 1'b0;
      wed_data   <= 1'b0;
    end else begin
      issue_q    <= issue;
      hold_valid <= enabled & issue_q;
      if (enabled && issue_q) begin
        // Half 0 straight from the store
        line_valid <= 1'b1;
        line_half  <= '0;
        read_data  <= half_words[0][STORE_READ_BIT];
        wed_data   <= half_words[0][STORE_WED_BIT];
      end else if (enabled && hold_valid) begin
        line_valid <= 1'b1;
        line_half  <= HALF_INDEX_WIDTH'(1);
        read_data  <= hold_word[STORE_READ_BIT];
        wed_data   <= hold_word[STORE_WED_BIT];
      end else begin
        line_valid <= 1'b0;
        read_data  <= 1'b0;
        wed_data   <= 1'b0;
      end
    end
  end

  // Half 1 waits one cycle in hold_word, tag stays for both beats
  always_ff @(posedge clock) begin
    if (issue_q) begin
      line_tag  <= issue_tag_q;
      line_data <= half_words[0][HALF_WIDTH-1:0];
      hold_word <= half_words[1];
    end else if (hold_valid) begin
      line_data <= hold_word[HALF_WIDTH-1:0];
    end
  end

endmodule

// File: hdl/read_buffer_top.sv
`timescale 1ns/1ps

module read_buffer_top
  import capi_pkg::*;
  import buffer_pkg::*;
(
  input  logic                        clock,
  input  logic                        rstn,
  input  logic                        enabled_in,
  // Command issue
  input  logic                        cmd_valid,
  input  logic [TAG_WIDTH-1:0]        cmd_tag,
  input  cmd_type_e                   cmd_type,
  // Half delivery
  input  logic                        write_valid,
  input  logic [TAG_WIDTH-1:0]        write_tag,
  input  logic                        write_tag_parity,
  input  logic [HALF_INDEX_WIDTH-1:0] write_half,
  input  logic [HALF_WIDTH-1:0]       write_data,
  input  logic [DW_PER_HALF-1:0]      write_parity,
  // Response
  input  logic                        response_valid,
  input  logic [TAG_WIDTH-1:0]        response_tag,
  // Released line
  output logic                        line_valid,
  output logic [TAG_WIDTH-1:0]        line_tag,
  output logic [HALF_INDEX_WIDTH-1:0] line_half,
  output logic [HALF_WIDTH-1:0]       line_data,
  output logic                        read_data,
  output logic                        wed_data,
  output logic [1:0]                  data_read_error
);

  logic [TAG_WIDTH-1:0]                   lookup_tag;
  cmd_type_e                              lookup_type;
  logic [HALF_COUNT-1:0]                  store_we;
  logic [TAG_WIDTH-1:0]                   store_tag;
  logic [STORE_WIDTH-1:0]                 store_word;
  logic [TAG_WIDTH-1:0]                   rd_tag;
  logic [HALF_COUNT-1:0][STORE_WIDTH-1:0] half_words;

  //////////////////////////////////////////////////////////////////////
  // Command kinds per tag
  //////////////////////////////////////////////////////////////////////

  tag_command_table i_tag_command_table (
    .clock      (clock),
    .rstn       (rstn),
    .cmd_valid  (cmd_valid),
    .cmd_tag    (cmd_tag),
    .cmd_type   (cmd_type),
    .lookup_tag (lookup_tag),
    .lookup_type(lookup_type)
  );

  //////////////////////////////////////////////////////////////////////
  // Feeder into the half stores
  //////////////////////////////////////////////////////////////////////

  read_data_control i_read_data_control (
    .clock           (clock),
    .rstn            (rstn),
    .enabled_in      (enabled_in),
    .write_valid     (write_valid),
    .write_tag       (write_tag),
    .write_tag_parity(write_tag_parity),
    .write_half      (write_half),
    .write_data      (write_data),
    .write_parity    (write_parity),
    .lookup_tag      (lookup_tag),
    .lookup_type     (lookup_type),
    .store_we        (store_we),
    .store_tag       (store_tag),
    .store_word      (store_word),
    .data_read_error (data_read_error)
  );

  // One store per half, all addressed by tag
  for (genvar h = 0; h < HALF_COUNT; h++) begin : g_store
    half_line_store #(
      .WIDTH(STORE_WIDTH),
      .DEPTH(TAG_COUNT)
    ) i_half_line_store (
      .clock   (clock),
      .we      (store_we[h]),
      .wr_addr (store_tag),
      .data_in (store_word),
      .rd_addr (rd_tag),
      .data_out(half_words[h])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Drain on response
  //////////////////////////////////////////////////////////////////////

  line_release i_line_release (
    .clock         (clock),
    .rstn          (rstn),
    .enabled_in    (enabled_in),
    .response_valid(response_valid),
    .response_tag  (response_tag),
    .rd_tag        (rd_tag),
    .half_words    (half_words),
    .line_valid    (line_valid),
    .line_tag      (line_tag),
    .line_half     (line_half),
    .line_data     (line_data),
    .read_data     (read_data),
    .wed_data      (wed_data)
  );

endmodule

// File: hdl/read_data_control.sv
`timescale 1ns/1ps

module read_data_control
  import capi_pkg::*;
  import buffer_pkg::*;
(
  input  logic                        clock,
  input  logic                        rstn,
  input  logic                        enabled_in,
  input  logic                        write_valid,
  input  logic [TAG_WIDTH-1:0]        write_tag,
  input  logic                        write_tag_parity,
  input  logic [HALF_INDEX_WIDTH-1:0] write_half,
  input  logic [HALF_WIDTH-1:0]       write_data,
  input  logic [DW_PER_HALF-1:0]      write_parity,
  output logic [TAG_WIDTH-1:0]        lookup_tag,
  input  cmd_type_e                   lookup_type,
  output logic [HALF_COUNT-1:0]       store_we,
  output logic [TAG_WIDTH-1:0]        store_tag,
  output logic [STORE_WIDTH-1:0]      store_word,
  output logic [1:0]                  data_read_error
);

  logic                        enabled;

  logic                        wr_valid_q;
  logic [TAG_WIDTH-1:0]        wr_tag_q;
  logic                        wr_tag_parity_q;
  logic [HALF_INDEX_WIDTH-1:0] wr_half_q;
  logic [HALF_WIDTH-1:0]       wr_data_q;
  logic [DW_PER_HALF-1:0]      wr_parity_q;

  logic                        tag_parity_calc;
  logic [DW_PER_HALF-1:0]      dw_parity_calc;
  logic                        tag_error;
  logic                        data_error;
  logic [1:0]                  error_pipe [ERROR_LATENCY];

  logic                        is_read;
  logic                        is_wed;

  //////////////////////////////////////////////////////////////////////
  // Enable and input latch
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled    <= 1'b0;
      wr_valid_q <= 1'b0;
    end else begin
      enabled    <= enabled_in;
      wr_valid_q <= enabled & write_valid;
    end
  end

  // Half payload, qualified by wr_valid_q
  always_ff @(posedge clock) begin
    if (write_valid) begin
      wr_tag_q        <= write_tag;
      wr_tag_parity_q <= write_tag_parity;
      wr_half_q       <= write_half;
      wr_data_q       <= write_data;
      wr_parity_q     <= write_parity;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Parity check
  //////////////////////////////////////////////////////////////////////

  assign tag_parity_calc = (^wr_tag_q) ^ ODD_PARITY;

  always_comb begin
    for (int i = 0; i < DW_PER_HALF; i++) begin
      dw_parity_calc[i] = (^wr_data_q[i*DW_WIDTH +: DW_WIDTH]) ^ ODD_PARITY;
    end
  end

  assign tag_error  = wr_valid_q & (tag_parity_calc != wr_tag_parity_q);
  assign data_error = wr_valid_q & (|(dw_parity_calc ^ wr_parity_q));

  // Three stages so the pulse lands at t+3
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < ERROR_LATENCY; i++) begin
        error_pipe[i] <= 2'b00;
      end
    end else begin
      error_pipe[0] <= {tag_error, data_error};
      for (int i = 1; i < ERROR_LATENCY; i++) begin
        error_pipe[i] <= error_pipe[i-1];
      end
    end
  end

  assign data_read_error = error_pipe[ERROR_LATENCY-1];

  //////////////////////////////////////////////////////////////////////
  // Command kind lookup and routing to the half stores
  //////////////////////////////////////////////////////////////////////

  assign lookup_tag = wr_tag_q;

  always_comb begin
    is_read = 1'b0;
    is_wed  = 1'b0;
    case (lookup_type)
      CMD_READ: is_read = 1'b1;
      CMD_WED:  is_wed  = 1'b1;
      default: begin
        is_read = 1'b0;
        is_wed  = 1'b0;
      end
    endcase
  end

  // Write enable per half, only for read and wed commands
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      store_we <= '0;
    end else begin
      for (int h = 0; h < HALF_COUNT; h++) begin
        store_we[h] <= wr_valid_q & (is_read | is_wed) &
                       (wr_half_q == HALF_INDEX_WIDTH'(h));
      end
    end
  end

  always_ff @(posedge clock) begin
    store_tag  <= wr_tag_q;
    store_word <= {is_read, is_wed, wr_data_q};
  end

endmodule

// File: hdl/tag_command_table.sv
`timescale 1ns/1ps

module tag_command_table
  import capi_pkg::*;
  import buffer_pkg::*;
(
  input  logic                 clock,
  input  logic                 rstn,
  input  logic                 cmd_valid,
  input  logic [TAG_WIDTH-1:0] cmd_tag,
  input  cmd_type_e            cmd_type,
  input  logic [TAG_WIDTH-1:0] lookup_tag,
  output cmd_type_e            lookup_type
);

  // One command kind per tag
  cmd_type_e table_q [TAG_COUNT];

  //////////////////////////////////////////////////////////////////////
  // Write at command issue
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < TAG_COUNT; i++) begin
        table_q[i] <= CMD_INVALID;
      end
    end else begin
      if (cmd_valid) begin
        table_q[cmd_tag] <= cmd_type;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Lookup by tag
  //////////////////////////////////////////////////////////////////////

  // Same cycle read for the feeder
  assign lookup_type = table_q[lookup_tag];

endmodule

// File: sources.f
hdl/capi_pkg.sv
hdl/buffer_pkg.sv
hdl/tag_command_table.sv
hdl/read_data_control.sv
hdl/half_line_store.sv
hdl/line_release.sv
hdl/read_buffer_top.sv
bench/read_buffer_assertions.sv
bench/read_buffer_tb.sv
